// ==== include/fir2d_config.svh ====
`ifndef FIR2D_CONFIG_SVH
`define FIR2D_CONFIG_SVH

// datapath widths
`define FIR2D_PIX_W   8
`define FIR2D_COEF_W  9   // signed
`define FIR2D_ACC_W   21  // nine full-scale products fit
`define FIR2D_SHIFT_W 4

// geometry
`define FIR2D_LINE_W  16  // pixels per line
`define FIR2D_TAPS    9   // 3x3 kernel

// config port
// taps at 0..8 in row-major order, shift at 9
`define FIR2D_ADDR_W  4

// centre tap after reset, every other tap and the shift start at 0
`define FIR2D_RESET_CENTER 1

`endif

// ==== source/fir2d_pkg.sv ====
`include "fir2d_config.svh"

package fir2d_pkg;

  typedef logic        [`FIR2D_PIX_W-1:0]   pixel_t;
  typedef logic signed [`FIR2D_COEF_W-1:0]  coef_t;
  typedef logic signed [`FIR2D_ACC_W-1:0]   acc_t;
  typedef logic        [`FIR2D_SHIFT_W-1:0] shift_t;

  // row 0 is the oldest line, column 0 the oldest pixel
  typedef pixel_t [`FIR2D_TAPS-1:0] window_t;
  typedef coef_t  [`FIR2D_TAPS-1:0] coef_set_t;

  typedef enum logic [1:0] {
    CFG_NOP    = 2'd0,
    CFG_WRITE  = 2'd1,  // load one shadow entry
    CFG_COMMIT = 2'd2   // shadow -> active
  } cfg_op_e;

endpackage

// ==== source/fir2d_window.sv ====
`include "fir2d_config.svh"

module fir2d_window (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               advance_i,
  input  logic               din_valid_i,
  input  logic               din_sop_i,
  input  logic               din_eop_i,
  input  fir2d_pkg::pixel_t  din_data_i,
  output logic               win_valid_o,
  output logic               win_sop_o,
  output logic               win_eop_o,
  output fir2d_pkg::window_t win_o
);

  localparam int K     = 3;
  localparam int COL_W = $clog2(`FIR2D_LINE_W);
  localparam int ROW_W = 8;

  logic             accept;
  logic [COL_W-1:0] col_q;
  logic [COL_W-1:0] col_cur;
  logic [ROW_W-1:0] row_q;
  logic [ROW_W-1:0] row_cur;
  logic             line_end;

  fir2d_pkg::pixel_t line_mem [2][`FIR2D_LINE_W];  // [0] one line back, [1] two lines back
  fir2d_pkg::pixel_t col_pix  [K];                 // current column, top = oldest line
  fir2d_pkg::pixel_t tap_q    [K][K-1];            // two previous columns per row

  assign accept   = advance_i & din_valid_i;
  assign col_cur  = din_sop_i ? '0 : col_q;  // sop restarts the frame on this beat
  assign row_cur  = din_sop_i ? '0 : row_q;
  assign line_end = (col_cur == COL_W'(`FIR2D_LINE_W - 1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      col_q <= '0;
      row_q <= '0;
    end else if (accept) begin
      col_q <= line_end ? '0 : col_cur + COL_W'(1);
      // row saturates, only rows 0..2 matter
      if (line_end && row_cur != '1)
        row_q <= row_cur + ROW_W'(1);
      else
        row_q <= row_cur;
    end
  end

  // line delays, one shift per accepted pixel
  always_ff @(posedge clk_i) begin
    if (accept) begin
      line_mem[0][0] <= din_data_i;
      line_mem[1][0] <= line_mem[0][`FIR2D_LINE_W-1];
      for (int i = 1; i < `FIR2D_LINE_W; i++) begin
        line_mem[0][i] <= line_mem[0][i-1];
        line_mem[1][i] <= line_mem[1][i-1];
      end
    end
  end

  assign col_pix[0] = line_mem[1][`FIR2D_LINE_W-1];
  assign col_pix[1] = line_mem[0][`FIR2D_LINE_W-1];
  assign col_pix[K-1] = din_data_i;  // newest line is live

  always_ff @(posedge clk_i) begin
    if (accept) begin
      for (int r = 0; r < K; r++) begin
        tap_q[r][0] <= tap_q[r][1];
        tap_q[r][1] <= col_pix[r];
      end
    end
  end

  // newest pixel ends up in the bottom-right cell
  always_comb begin
    for (int r = 0; r < K; r++) begin
      win_o[K*r]     = tap_q[r][0];
      win_o[K*r + 1] = tap_q[r][1];
      win_o[K*r + 2] = col_pix[r];
    end
  end

  assign win_valid_o = accept & (row_cur >= ROW_W'(2)) & (col_cur >= COL_W'(2));
  assign win_sop_o   = win_valid_o & (row_cur == ROW_W'(2)) & (col_cur == COL_W'(2));
  assign win_eop_o   = win_valid_o & din_eop_i;

endmodule

// ==== source/fir2d_coef_bank.sv ====
`include "fir2d_config.svh"

module fir2d_coef_bank (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  fir2d_pkg::cfg_op_e       cfg_op_i,
  input  logic [`FIR2D_ADDR_W-1:0] cfg_addr_i,
  input  fir2d_pkg::coef_t         cfg_data_i,
  output fir2d_pkg::coef_set_t     coef_o,
  output fir2d_pkg::shift_t        shift_o
);

  localparam int CENTER = `FIR2D_TAPS / 2;
  localparam logic [`FIR2D_ADDR_W-1:0] SHIFT_ADDR = `FIR2D_TAPS;

  // identity kernel
  localparam fir2d_pkg::coef_set_t RESET_COEF =
    fir2d_pkg::coef_set_t'(`FIR2D_RESET_CENTER) << (CENTER * `FIR2D_COEF_W);

  fir2d_pkg::coef_set_t shadow_coef;
  fir2d_pkg::shift_t    shadow_shift;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shadow_coef  <= RESET_COEF;
      shadow_shift <= '0;
      coef_o       <= RESET_COEF;
      shift_o      <= '0;
    end else begin
      case (cfg_op_i)
        fir2d_pkg::CFG_WRITE: begin
          if (cfg_addr_i < SHIFT_ADDR)
            shadow_coef[cfg_addr_i] <= cfg_data_i;
          else if (cfg_addr_i == SHIFT_ADDR)
            shadow_shift <= cfg_data_i[`FIR2D_SHIFT_W-1:0];
          // anything above the shift address is dropped
        end
        fir2d_pkg::CFG_COMMIT: begin
          coef_o  <= shadow_coef;   // whole set at once
          shift_o <= shadow_shift;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== source/fir2d_mac.sv ====
`include "fir2d_config.svh"

module fir2d_mac (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 advance_i,
  input  logic                 win_valid_i,
  input  logic                 win_sop_i,
  input  logic                 win_eop_i,
  input  fir2d_pkg::window_t   win_i,
  input  fir2d_pkg::coef_set_t coef_i,
  input  fir2d_pkg::shift_t    shift_i,
  output logic                 dout_valid_o,
  output logic                 dout_sop_o,
  output logic                 dout_eop_o,
  output fir2d_pkg::pixel_t    dout_data_o
);

  localparam int K = 3;
  localparam fir2d_pkg::acc_t PIX_MAX = fir2d_pkg::acc_t'((1 << `FIR2D_PIX_W) - 1);

  fir2d_pkg::acc_t   prod_q [`FIR2D_TAPS];
  fir2d_pkg::acc_t   row_q  [K];
  fir2d_pkg::acc_t   total;
  fir2d_pkg::acc_t   scaled;
  fir2d_pkg::pixel_t clamped;

  // stage flags, [0] after stage 1, [1] after stage 2
  logic [1:0] vld_q;
  logic [1:0] sop_q;
  logic [1:0] eop_q;

  // stage 1 : products, pixel taken as unsigned
  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      for (int i = 0; i < `FIR2D_TAPS; i++)
        prod_q[i] <= $signed({1'b0, win_i[i]}) * $signed(coef_i[i]);
    end
  end

  // stage 2 : one sum per window row
  always_ff @(posedge clk_i) begin
    if (advance_i) begin
      for (int r = 0; r < K; r++)
        row_q[r] <= prod_q[K*r] + prod_q[K*r + 1] + prod_q[K*r + 2];
    end
  end

  // stage 3 input
  always_comb begin
    total  = row_q[0] + row_q[1] + row_q[2];
    scaled = total >>> shift_i;  // arithmetic, keeps the sign
    if (scaled < 0)
      clamped = '0;
    else if (scaled > PIX_MAX)
      clamped = '1;
    else
      clamped = scaled[`FIR2D_PIX_W-1:0];
  end

  always_ff @(posedge clk_i) begin
    if (advance_i)
      dout_data_o <= clamped;
  end

  // flags ride alongside the data
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_q        <= '0;
      sop_q        <= '0;
      eop_q        <= '0;
      dout_valid_o <= 1'b0;
      dout_sop_o   <= 1'b0;
      dout_eop_o   <= 1'b0;
    end else if (advance_i) begin
      vld_q        <= {vld_q[0], win_valid_i};
      sop_q        <= {sop_q[0], win_sop_i};
      eop_q        <= {eop_q[0], win_eop_i};
      dout_valid_o <= vld_q[1];
      dout_sop_o   <= sop_q[1];
      dout_eop_o   <= eop_q[1];
    end
  end

endmodule

// ==== source/fir2d_top.sv ====
`include "fir2d_config.svh"

module fir2d_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     din_valid_i,
  output logic                     din_ready_o,
  input  logic                     din_sop_i,
  input  logic                     din_eop_i,
  input  fir2d_pkg::pixel_t        din_data_i,
  output logic                     dout_valid_o,
  input  logic                     dout_ready_i,
  output logic                     dout_sop_o,
  output logic                     dout_eop_o,
  output fir2d_pkg::pixel_t        dout_data_o,
  input  fir2d_pkg::cfg_op_e       cfg_op_i,
  input  logic [`FIR2D_ADDR_W-1:0] cfg_addr_i,
  input  fir2d_pkg::coef_t         cfg_data_i
);

  logic                 advance;
  logic                 win_valid;
  logic                 win_sop;
  logic                 win_eop;
  fir2d_pkg::window_t   window;
  fir2d_pkg::coef_set_t coef;
  fir2d_pkg::shift_t    shift;

  // whole pipeline freezes while a result waits at the output
  assign advance     = !(dout_valid_o && !dout_ready_i);
  assign din_ready_o = advance;

  fir2d_window i_window (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .advance_i   (advance),
    .din_valid_i (din_valid_i),
    .din_sop_i   (din_sop_i),
    .din_eop_i   (din_eop_i),
    .din_data_i  (din_data_i),
    .win_valid_o (win_valid),
    .win_sop_o   (win_sop),
    .win_eop_o   (win_eop),
    .win_o       (window)
  );

  fir2d_coef_bank i_coef_bank (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cfg_op_i   (cfg_op_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_data_i (cfg_data_i),
    .coef_o     (coef),
    .shift_o    (shift)
  );

  fir2d_mac i_mac (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .advance_i    (advance),
    .win_valid_i  (win_valid),
    .win_sop_i    (win_sop),
    .win_eop_i    (win_eop),
    .win_i        (window),
    .coef_i       (coef),
    .shift_i      (shift),
    .dout_valid_o (dout_valid_o),
    .dout_sop_o   (dout_sop_o),
    .dout_eop_o   (dout_eop_o),
    .dout_data_o  (dout_data_o)
  );

endmodule

// ==== verif/fir2d_asserts.sv ====
`include "fir2d_config.svh"

module fir2d_asserts (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     din_valid_i,
  input logic                     din_ready_o,
  input fir2d_pkg::pixel_t        din_data_i,
  input logic                     dout_valid_o,
  input logic                     dout_ready_i,
  input logic                     dout_sop_o,
  input logic                     dout_eop_o,
  input fir2d_pkg::pixel_t        dout_data_o,
  input fir2d_pkg::cfg_op_e       cfg_op_i,
  input logic [`FIR2D_ADDR_W-1:0] cfg_addr_i,
  input fir2d_pkg::coef_t         cfg_data_i
);

  localparam int CENTER     = `FIR2D_TAPS / 2;
  localparam int FRAME_OUTS = (`FIR2D_LINE_W - 2) * 4;  // six-line frames

  int                err_cnt = 0;
  int                shadow [`FIR2D_TAPS];
  int                shadow_sum;
  int                shadow_shift;
  int                coef_sum;  // committed kernel
  int                act_shift;
  int                out_cnt;
  fir2d_pkg::pixel_t last_pix;
  fir2d_pkg::pixel_t exp_pix;
  logic              xfer;

  // constant input p gives p * sum of taps, then shift and clamp
  function automatic fir2d_pkg::pixel_t const_response(input int p, input int sum, input int sh);
    int v;
    v = (p * sum) >>> sh;
    if (v < 0)
      return 8'd0;
    if (v > 255)
      return 8'd255;
    return fir2d_pkg::pixel_t'(v);
  endfunction

  always_comb begin
    shadow_sum = 0;
    for (int i = 0; i < `FIR2D_TAPS; i++)
      shadow_sum += shadow[i];
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `FIR2D_TAPS; i++)
        shadow[i] <= (i == CENTER) ? `FIR2D_RESET_CENTER : 0;
      shadow_shift <= 0;
      coef_sum     <= `FIR2D_RESET_CENTER;
      act_shift    <= 0;
    end else if (cfg_op_i == fir2d_pkg::CFG_WRITE) begin
      if (cfg_addr_i < `FIR2D_TAPS)
        shadow[cfg_addr_i] <= int'(cfg_data_i);  // sign extended
      else if (cfg_addr_i == `FIR2D_TAPS)
        shadow_shift <= int'(cfg_data_i[`FIR2D_SHIFT_W-1:0]);
    end else if (cfg_op_i == fir2d_pkg::CFG_COMMIT) begin
      coef_sum  <= shadow_sum;
      act_shift <= shadow_shift;
    end
  end

  assign xfer    = dout_valid_o && dout_ready_i;
  assign exp_pix = const_response(int'(last_pix), coef_sum, act_shift);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_pix <= '0;
      out_cnt  <= 0;
    end else begin
      if (din_valid_i && din_ready_o)
        last_pix <= din_data_i;
      if (xfer)
        out_cnt <= dout_eop_o ? 0 : out_cnt + 1;  // position within the frame
    end
  end

  a_reset_idle: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !dout_valid_o && din_ready_o)
    else begin err_cnt++; $error("output valid or input not ready right after reset"); end

  a_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dout_valid_o |-> dout_data_o == exp_pix)
    else begin
      err_cnt++;
      $error("ERR %0t: output %0d, expected %0d", $time, $sampled(dout_data_o),
             $sampled(exp_pix));
    end

  a_sop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    xfer |-> dout_sop_o == (out_cnt == 0))
    else begin err_cnt++; $error("start of frame flag missing or on the wrong output"); end

  a_eop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    xfer |-> dout_eop_o == (out_cnt == FRAME_OUTS - 1))
    else begin err_cnt++; $error("end of frame flag missing or frame has wrong length"); end

  a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dout_valid_o && !dout_ready_i |=> dout_valid_o && $stable(dout_data_o)
      && $stable(dout_sop_o) && $stable(dout_eop_o))
    else begin err_cnt++; $error("output changed while stalled"); end

  a_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dout_valid_o && !dout_ready_i |-> !din_ready_o)
    else begin err_cnt++; $error("input ready while output is stalled"); end

endmodule

bind fir2d_top fir2d_asserts i_asserts (.*);

// ==== verif/fir2d_tb.sv ====
`include "fir2d_config.svh"

module fir2d_tb;

  localparam int CLK_PERIOD  = 4;
  localparam int LINES       = 6;
  localparam int FRAME_BEATS = LINES * `FIR2D_LINE_W;
  localparam int FRAMES      = 5;
  localparam int CENTER      = `FIR2D_TAPS / 2;
  // twice the run with every beat taking three cycles
  localparam int TIMEOUT     = 2 * FRAMES * FRAME_BEATS * 3 * CLK_PERIOD;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     din_valid;
  logic                     din_ready;
  logic                     din_sop;
  logic                     din_eop;
  fir2d_pkg::pixel_t        din_data;
  logic                     dout_valid;
  logic                     dout_ready;
  logic                     dout_sop;
  logic                     dout_eop;
  fir2d_pkg::pixel_t        dout_data;
  fir2d_pkg::cfg_op_e       cfg_op;
  logic [`FIR2D_ADDR_W-1:0] cfg_addr;
  fir2d_pkg::coef_t         cfg_data;
  int unsigned              gap_state;
  int unsigned              ready_state;
  int                       frames_done;

  always #(CLK_PERIOD / 2) clk = ~clk;

  fir2d_top i_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .din_valid_i  (din_valid),
    .din_ready_o  (din_ready),
    .din_sop_i    (din_sop),
    .din_eop_i    (din_eop),
    .din_data_i   (din_data),
    .dout_valid_o (dout_valid),
    .dout_ready_i (dout_ready),
    .dout_sop_o   (dout_sop),
    .dout_eop_o   (dout_eop),
    .dout_data_o  (dout_data),
    .cfg_op_i     (cfg_op),
    .cfg_addr_i   (cfg_addr),
    .cfg_data_i   (cfg_data)
  );

  function automatic int unsigned lcg_step(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic bit take_gap();
    gap_state = lcg_step(gap_state);
    return ((gap_state >> 16) % 4) == 0;  // idle beat now and then
  endfunction

  // back-pressure, low about a third of the time
  always @(posedge clk) begin
    ready_state = lcg_step(ready_state);
    dout_ready <= ((ready_state >> 16) % 3) != 0;
  end

  always @(posedge clk)
    if (dout_valid && dout_ready && dout_eop)
      frames_done <= frames_done + 1;

  task automatic send_frame(input fir2d_pkg::pixel_t value);
    int idx;
    bit taken;
    idx = 0;
    while (idx < FRAME_BEATS) begin
      @(posedge clk);
      taken = din_valid && din_ready;
      if (taken)
        idx++;
      if (idx == FRAME_BEATS) begin
        din_valid <= 1'b0;
        din_eop   <= 1'b0;
      end else if (taken || !din_valid) begin  // a held beat stays put
        din_valid <= !take_gap();
        din_sop   <= (idx == 0);
        din_eop   <= (idx == FRAME_BEATS - 1);
        din_data  <= value;
      end
    end
  endtask

  task automatic run_frame(input fir2d_pkg::pixel_t value);
    int target;
    target = frames_done + 1;
    send_frame(value);
    while (frames_done < target)  // drain the pipeline
      @(posedge clk);
  endtask

  task automatic write_cfg(input int addr, input fir2d_pkg::coef_t data);
    @(posedge clk);
    cfg_op   <= fir2d_pkg::CFG_WRITE;
    cfg_addr <= `FIR2D_ADDR_W'(addr);
    cfg_data <= data;
  endtask

  // shadow only, nothing takes effect before a commit
  task automatic load_kernel(input fir2d_pkg::coef_t center, input fir2d_pkg::coef_t outer,
                             input int shift_amt);
    for (int a = 0; a < `FIR2D_TAPS; a++)
      write_cfg(a, (a == CENTER) ? center : outer);
    write_cfg(`FIR2D_TAPS, fir2d_pkg::coef_t'(shift_amt));
    @(posedge clk);
    cfg_op <= fir2d_pkg::CFG_NOP;
  endtask

  task automatic commit_cfg();
    @(posedge clk);
    cfg_op <= fir2d_pkg::CFG_COMMIT;
    @(posedge clk);
    cfg_op <= fir2d_pkg::CFG_NOP;
  endtask

  initial begin
    #(TIMEOUT);
    $display("timeout: frames still incomplete after %0d time units", TIMEOUT);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    rst_n       = 1'b0;
    din_valid   = 1'b0;
    din_sop     = 1'b0;
    din_eop     = 1'b0;
    din_data    = '0;
    dout_ready  = 1'b0;
    cfg_op      = fir2d_pkg::CFG_NOP;
    cfg_addr    = '0;
    cfg_data    = '0;
    gap_state   = 75;
    ready_state = lcg_step(75);
    frames_done = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    run_frame(8'd100);  // identity kernel from reset
    load_kernel(9'sd1, 9'sd1, 3);
    commit_cfg();
    run_frame(8'd80);
    fork
      run_frame(8'd200);
      begin
        repeat (20) @(posedge clk);
        load_kernel(9'sd0, 9'sd0, 0);  // never committed
      end
    join
    load_kernel(-9'sd2, 9'sd0, 0);
    commit_cfg();
    run_frame(8'd50);
    load_kernel(9'sd0, 9'sd1, 0);
    commit_cfg();
    run_frame(8'd60);
    repeat (4) @(posedge clk);

    $display("frames %0d of %0d, assertion failures %0d", frames_done, FRAMES,
             i_dut.i_asserts.err_cnt);
    if (i_dut.i_asserts.err_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
source/fir2d_pkg.sv
source/fir2d_window.sv
source/fir2d_coef_bank.sv
source/fir2d_mac.sv
source/fir2d_top.sv
verif/fir2d_asserts.sv
verif/fir2d_tb.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' build.f) include/fir2d_config.svh

.PHONY: run clean

run: obj_dir/Vfir2d_tb
	./obj_dir/Vfir2d_tb +verilator+error+limit+100 | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null

obj_dir/Vfir2d_tb: build.f $(SRCS)
	verilator --binary --assert -Wno-fatal -f build.f --top-module fir2d_tb -o Vfir2d_tb

clean:
	rm -rf obj_dir
